/* vlog.f */
common/cpuPkg.sv
common/excPkg.sv
common/memReqIf.sv
hw/memReg.sv
hw/lsuFormat.sv
cp0/cp0Regs.sv
cp0/exceptionUnit.sv
hw/apbDataMaster.sv
hw/memStage.sv
test/memStageTb.sv

/* run.sh */
#!/bin/bash
# build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module memStageTb -f vlog.f -o memStageSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/memStageSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

/* test/memStageTb.sv */
// Memory stage testbench
`timescale 1ns/1ps

module memStageTb;

    localparam int instrCount = 400;
    localparam int memWords   = 64;

    logic              clk;
    logic              arstN;
    logic              exeValid;
    logic              exeSyscall;
    logic              exeOverflow;
    logic              exeRegWr;
    cpuPkg::word_t     exeAluOut;
    cpuPkg::word_t     exeStoreData;
    cpuPkg::word_t     exePc;
    cpuPkg::regAddr_t  exeDst;
    cpuPkg::memOp_t    exeMemOp;
    cpuPkg::cp0Op_t    exeCp0Op;
    excPkg::cp0Addr_t  exeCp0Addr;
    cpuPkg::irq_t      interrupt;
    logic              memValid;
    logic              memRegWr;
    cpuPkg::word_t     memResult;
    cpuPkg::regAddr_t  memDst;
    logic              stall;
    logic              flushException;
    cpuPkg::word_t     excVector;
    cpuPkg::word_t     epc;
    cpuPkg::word_t     paddr;
    cpuPkg::word_t     pwdata;
    logic              psel;
    logic              penable;
    logic              pwrite;
    cpuPkg::strb_t     pstrb;
    cpuPkg::word_t     prdata;
    logic              pready;

    // slave memory and reference copy
    cpuPkg::word_t     slaveMem [memWords];
    cpuPkg::word_t     modelMem [memWords];
    int                apbCount;

    // reference CP0 state
    logic              modelBev;
    logic [7:0]        modelIm;
    logic              modelExl;
    logic              modelIe;
    logic [1:0]        modelSoftIp;
    cpuPkg::word_t     modelEpc;
    excPkg::excCode_t  modelCode;
    logic              lastTook;

    memStage uut (.*);

    always #20 clk = ~clk;

    task automatic checkWord(input string name, input cpuPkg::word_t exp,
                             input cpuPkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkReg(input string name, input cpuPkg::regAddr_t exp,
                            input cpuPkg::regAddr_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic checkCode(input string name, input excPkg::excCode_t exp,
                             input excPkg::excCode_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic protocolError(input string what);
        $display("APB protocol error: %s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic cpuPkg::word_t fillWord(input int i);
        return (32'(i) * 32'h0101_0101) ^ 32'hA5C3_0F96 ^ (32'(i) << 27);
    endfunction

    // sign or zero extended lane of a read word
    function automatic cpuPkg::word_t extendLoad(input cpuPkg::memOp_t op,
                                                 input cpuPkg::word_t w, input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            cpuPkg::memLb:  return {{24{b[7]}}, b};
            cpuPkg::memLbu: return {24'b0, b};
            cpuPkg::memLh:  return {{16{h[15]}}, h};
            cpuPkg::memLhu: return {16'b0, h};
            default:        return w;
        endcase
    endfunction

    // store bytes land in the addressed lanes only
    function automatic cpuPkg::word_t mergeStore(input cpuPkg::memOp_t op,
            input cpuPkg::word_t old, input cpuPkg::word_t data, input logic [1:0] off);
        cpuPkg::word_t res;
        res = old;
        for (int k = 0; k < 4; k++) begin
            if (op == cpuPkg::memSw) begin
                res[8*k +: 8] = data[8*k +: 8];
            end else if (op == cpuPkg::memSh && (k / 2) == int'(off[1])) begin
                res[8*k +: 8] = data[8*(k%2) +: 8];
            end else if (op == cpuPkg::memSb && k == int'(off)) begin
                res[8*k +: 8] = data[7:0];
            end
        end
        return res;
    endfunction

    // APB slave with random wait states and protocol monitor
    int            waitLeft;
    logic          setupSeen;
    cpuPkg::word_t latAddr;
    cpuPkg::word_t latData;
    logic          latWrite;
    cpuPkg::strb_t latStrb;

    always @(posedge clk) begin
        if (setupSeen && !(psel && penable)) begin
            protocolError("setup phase not followed by an access phase");
        end
        if (penable && !psel) begin
            protocolError("penable high without psel");
        end
        if (psel && penable) begin
            if (latAddr !== paddr || latWrite !== pwrite
                || latData !== pwdata || latStrb !== pstrb) begin
                protocolError("transfer signals changed before pready");
            end
        end
        if (psel && !penable) begin
            setupSeen = 1'b1;
            latAddr   = paddr;
            latWrite  = pwrite;
            latData   = pwdata;
            latStrb   = pstrb;
            apbCount  = apbCount + 1;
            waitLeft  = $urandom % 4;
            #2;
            prdata = slaveMem[paddr[7:2]];
            pready = (waitLeft == 0);
        end else if (psel && penable) begin
            setupSeen = 1'b0;
            if (pready) begin
                if (pwrite) begin
                    for (int k = 0; k < 4; k++) begin
                        if (pstrb[k]) slaveMem[paddr[7:2]][8*k +: 8] = pwdata[8*k +: 8];
                    end
                end
                #2 pready = 1'b0;
            end else begin
                waitLeft = waitLeft - 1;
                #2 pready = (waitLeft == 0);
            end
        end
    end

    task automatic executeInstr(input cpuPkg::memOp_t op, input cpuPkg::cp0Op_t cop,
            input excPkg::cp0Addr_t caddr, input cpuPkg::word_t alu, input cpuPkg::word_t sdata,
            input cpuPkg::word_t pc, input cpuPkg::regAddr_t dst, input logic regWr,
            input logic sys, input logic ov, input cpuPkg::irq_t irq);
        logic             isLd;
        logic             isSt;
        logic             mis;
        logic             intr;
        logic             take;
        logic             eretTaken;
        excPkg::excCode_t code;
        cpuPkg::word_t    rdVal;
        cpuPkg::word_t    expResult;
        logic [1:0]       off;
        int               idx;
        int               startCount;
        isLd = op inside {cpuPkg::memLb, cpuPkg::memLbu, cpuPkg::memLh,
                          cpuPkg::memLhu, cpuPkg::memLw};
        isSt = op inside {cpuPkg::memSb, cpuPkg::memSh, cpuPkg::memSw};
        off  = alu[1:0];
        idx  = int'(alu[7:2]);
        mis  = (op inside {cpuPkg::memLh, cpuPkg::memLhu, cpuPkg::memSh}) ? off[0] :
               (op inside {cpuPkg::memLw, cpuPkg::memSw}) ? (off != 2'b00) : 1'b0;
        intr = modelIe && !modelExl && (({irq, modelSoftIp} & modelIm) != 8'h00);
        take = intr || (isLd && mis) || (isSt && mis) || sys || ov;
        eretTaken = !take && cop == cpuPkg::cp0Eret;
        if (intr) code = excPkg::excInt;
        else if (isLd && mis) code = excPkg::excAdel;
        else if (isSt && mis) code = excPkg::excAdes;
        else if (ov) code = excPkg::excOv;
        else code = excPkg::excSys;
        case (caddr)
            excPkg::cp0Status: rdVal = {9'b0, modelBev, 6'b0, modelIm, 6'b0, modelExl, modelIe};
            excPkg::cp0Cause:  rdVal = {16'b0, irq, modelSoftIp, 1'b0, modelCode, 2'b0};
            excPkg::cp0Epc:    rdVal = modelEpc;
            default:           rdVal = '0;
        endcase
        if (isLd) expResult = extendLoad(op, modelMem[idx], off);
        else if (cop == cpuPkg::cp0Mfc0) expResult = rdVal;
        else expResult = alu;
        startCount = apbCount;

        @(posedge clk);
        #2;
        exeValid     = 1'b1;
        exeMemOp     = op;
        exeCp0Op     = cop;
        exeCp0Addr   = caddr;
        exeAluOut    = alu;
        exeStoreData = sdata;
        exePc        = pc;
        exeDst       = dst;
        exeRegWr     = regWr;
        exeSyscall   = sys;
        exeOverflow  = ov;
        interrupt    = irq;
        @(posedge clk);
        #2;
        // a store offered in a flush cycle must be dropped
        exeValid    = take || eretTaken;
        exeMemOp    = cpuPkg::memSw;
        exeCp0Op    = cpuPkg::cp0None;
        exeAluOut   = 32'h0000_1000;
        exeSyscall  = 1'b0;
        exeOverflow = 1'b0;
        @(negedge clk);
        while (!memValid) begin
            checkBit("stall while held", 1'b1, stall);
            @(negedge clk);
        end
        checkBit("stall at completion", 1'b0, stall);
        checkBit("flushException", take || eretTaken, flushException);
        checkWord("epc before update", modelEpc, epc);
        if (take) checkWord("exception vector", modelBev ? 32'hBFC0_0380 : 32'h8000_0180,
                            excVector);
        if (eretTaken) checkWord("eret vector", modelEpc, excVector);
        checkBit("memRegWr", regWr && !take && !eretTaken, memRegWr);
        checkReg("memDst", dst, memDst);
        if ((isLd || isSt) && !take) begin
            checkWord("paddr", {alu[31:2], 2'b00}, latAddr);
            checkBit("pwrite", isSt, latWrite);
        end
        if (!take && !eretTaken) begin
            if (cop == cpuPkg::cp0Mfc0 && caddr == excPkg::cp0Cause) begin
                checkCode("cause code", modelCode, excPkg::excCode_t'(memResult[6:2]));
            end
            checkWord("memResult", expResult, memResult);
        end

        // reference update
        if (take) begin
            modelExl  = 1'b1;
            modelCode = code;
            modelEpc  = pc;
        end else if (eretTaken) begin
            modelExl = 1'b0;
        end else begin
            if (cop == cpuPkg::cp0Mtc0) begin
                case (caddr)
                    excPkg::cp0Status: begin
                        modelBev = sdata[22];
                        modelIm  = sdata[15:8];
                        modelExl = sdata[1];
                        modelIe  = sdata[0];
                    end
                    excPkg::cp0Cause: modelSoftIp = sdata[9:8];
                    excPkg::cp0Epc:   modelEpc = sdata;
                    default: ;
                endcase
            end
            if (isSt) modelMem[idx] = mergeStore(op, modelMem[idx], sdata, off);
        end
        lastTook = take;

        @(posedge clk);
        #2 exeValid = 1'b0;
        @(negedge clk);
        checkBit("no completion after", 1'b0, memValid);
        checkBit("nothing held after", 1'b0, stall);
        checkBit("psel idle after", 1'b0, psel);
        checkWord("apb transfers", ((isLd || isSt) && !take) ? 1 : 0, apbCount - startCount);
        checkWord("epc after update", modelEpc, epc);
        if (isSt && !take) checkWord("store memory word", modelMem[idx], slaveMem[idx]);
    endtask

    // watchdog sized from the instruction count
    initial begin
        #(instrCount * 8 * 40);
        $display("Simulation hung: instructions did not complete in time");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        cpuPkg::memOp_t   op;
        cpuPkg::cp0Op_t   cop;
        excPkg::cp0Addr_t caddr;
        cpuPkg::word_t    alu;
        cpuPkg::irq_t     irq;
        logic [1:0]       off;
        int               kind;
        void'($urandom(64));
        clk = 1'b0;
        arstN = 1'b0;
        exeValid = 1'b0;
        exeSyscall = 1'b0;
        exeOverflow = 1'b0;
        exeRegWr = 1'b0;
        exeAluOut = '0;
        exeStoreData = '0;
        exePc = '0;
        exeDst = '0;
        exeMemOp = cpuPkg::memNone;
        exeCp0Op = cpuPkg::cp0None;
        exeCp0Addr = '0;
        interrupt = '0;
        prdata = '0;
        pready = 1'b0;
        apbCount = 0;
        setupSeen = 1'b0;
        latAddr = '0;
        latData = '0;
        latWrite = 1'b0;
        latStrb = '0;
        modelBev = 1'b1;
        modelIm = '0;
        modelExl = 1'b0;
        modelIe = 1'b0;
        modelSoftIp = '0;
        modelEpc = '0;
        modelCode = '0;
        lastTook = 1'b0;
        irq = '0;
        for (int i = 0; i < memWords; i++) begin
            slaveMem[i] = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        repeat (16) @(posedge clk);
        #2 arstN = 1'b1;

        for (int n = 0; n < instrCount; n++) begin
            if ($urandom % 8 == 0) irq = ($urandom % 2 == 0) ? '0 : 6'($urandom);
            kind  = $urandom % 10;
            op    = cpuPkg::memNone;
            cop   = cpuPkg::cp0None;
            caddr = 5'd12 + 5'($urandom % 3);
            off   = 2'($urandom);
            if (kind <= 4) begin
                op = (kind <= 2) ? cpuPkg::memOp_t'(4'(1 + $urandom % 5)) :
                                   cpuPkg::memOp_t'(4'(6 + $urandom % 3));
                // mostly aligned with one in eight misaligned
                if ($urandom % 8 != 0) begin
                    if (op inside {cpuPkg::memLh, cpuPkg::memLhu, cpuPkg::memSh}) off[0] = 1'b0;
                    if (op inside {cpuPkg::memLw, cpuPkg::memSw}) off = 2'b00;
                end
                alu = 32'h0000_1000 | {24'b0, 6'($urandom), off};
            end else begin
                alu = $urandom;
            end
            if (kind == 6) cop = cpuPkg::cp0Mtc0;
            if (kind == 7) cop = cpuPkg::cp0Mfc0;
            if (kind == 8) cop = cpuPkg::cp0Eret;
            executeInstr(op, cop, caddr, alu, $urandom, $urandom & 32'hFFFF_FFFC,
                         5'($urandom), 1'($urandom), kind == 9 && $urandom % 2 == 0,
                         kind == 9 && $urandom % 2 == 0 || kind == 9 && n % 3 == 0, irq);
            // read the code back after every exception
            if (lastTook) begin
                executeInstr(cpuPkg::memNone, cpuPkg::cp0Mfc0, excPkg::cp0Cause, '0, '0,
                             32'h0040_0000, 5'd3, 1'b1, 1'b0, 1'b0, irq);
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* hw/memStage.sv */
// Memory stage top level
`timescale 1ns/1ps

module memStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              exeValid,
    input  logic              exeSyscall,
    input  logic              exeOverflow,
    input  logic              exeRegWr,
    input  cpuPkg::word_t     exeAluOut,
    input  cpuPkg::word_t     exeStoreData,
    input  cpuPkg::word_t     exePc,
    input  cpuPkg::regAddr_t  exeDst,
    input  cpuPkg::memOp_t    exeMemOp,
    input  cpuPkg::cp0Op_t    exeCp0Op,
    input  excPkg::cp0Addr_t  exeCp0Addr,
    input  cpuPkg::irq_t      interrupt,
    output logic              memValid,
    output logic              memRegWr,
    output cpuPkg::word_t     memResult,
    output cpuPkg::regAddr_t  memDst,
    output logic              stall,
    output logic              flushException,
    output cpuPkg::word_t     excVector,
    output cpuPkg::word_t     epc,
    output cpuPkg::word_t     paddr,
    output cpuPkg::word_t     pwdata,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output cpuPkg::strb_t     pstrb,
    input  cpuPkg::word_t     prdata,
    input  logic              pready
);
    logic              heldValid;
    logic              heldSyscall;
    logic              heldOverflow;
    cpuPkg::word_t     heldAluOut;
    cpuPkg::word_t     heldStoreData;
    cpuPkg::word_t     heldPc;
    logic              heldRegWr;
    cpuPkg::memOp_t    heldMemOp;
    cpuPkg::cp0Op_t    heldCp0Op;
    excPkg::cp0Addr_t  heldCp0Addr;
    logic              isLoad;
    logic              isStore;
    logic              misaligned;
    logic              accessBusy;
    logic              intPending;
    logic              statusBev;
    logic              excTake;
    logic              eretTake;
    excPkg::excCode_t  excCode;
    excPkg::excCause_t cause;
    cpuPkg::word_t     loadData;
    cpuPkg::word_t     cp0RdData;

    memReqIf dataReq ();

    memReg uMemReg (
        .clk          (clk),
        .arstN        (arstN),
        .hold         (stall),
        .flush        (flushException),
        .exeValid     (exeValid),
        .exeSyscall   (exeSyscall),
        .exeOverflow  (exeOverflow),
        .exeAluOut    (exeAluOut),
        .exeStoreData (exeStoreData),
        .exePc        (exePc),
        .exeDst       (exeDst),
        .exeRegWr     (exeRegWr),
        .exeMemOp     (exeMemOp),
        .exeCp0Op     (exeCp0Op),
        .exeCp0Addr   (exeCp0Addr),
        .memValid     (heldValid),
        .memSyscall   (heldSyscall),
        .memOverflow  (heldOverflow),
        .memAluOut    (heldAluOut),
        .memStoreData (heldStoreData),
        .memPc        (heldPc),
        .memDst       (memDst),
        .memRegWr     (heldRegWr),
        .memMemOp     (heldMemOp),
        .memCp0Op     (heldCp0Op),
        .memCp0Addr   (heldCp0Addr)
    );

    assign isLoad  = heldMemOp inside {cpuPkg::memLb, cpuPkg::memLbu, cpuPkg::memLh,
                                       cpuPkg::memLhu, cpuPkg::memLw};
    assign isStore = heldMemOp inside {cpuPkg::memSb, cpuPkg::memSh, cpuPkg::memSw};

    lsuFormat uLsuFormat (
        .memOp      (heldMemOp),
        .addr       (heldAluOut),
        .storeData  (heldStoreData),
        .rdata      (dataReq.rdata),
        .strb       (dataReq.strb),
        .wdata      (dataReq.wdata),
        .loadData   (loadData),
        .misaligned (misaligned)
    );

    // interrupts wait while a bus transfer is in flight
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            accessBusy <= 1'b0;
        end else if (dataReq.done) begin
            accessBusy <= 1'b0;
        end else if (dataReq.valid) begin
            accessBusy <= 1'b1;
        end
    end

    assign cause.interrupt = intPending && !accessBusy;
    assign cause.adel      = isLoad && misaligned;
    assign cause.ades      = isStore && misaligned;
    assign cause.syscall   = heldSyscall;
    assign cause.overflow  = heldOverflow;

    // only clean loads and stores reach the bus
    assign dataReq.valid = heldValid && (isLoad || isStore) && !(|cause);
    assign dataReq.write = isStore;
    assign dataReq.addr  = {heldAluOut[31:2], 2'b00};

    apbDataMaster uApbDataMaster (
        .clk     (clk),
        .arstN   (arstN),
        .req     (dataReq.master),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

    exceptionUnit uExceptionUnit (
        .valid     (heldValid),
        .cause     (cause),
        .isEret    (heldCp0Op == cpuPkg::cp0Eret),
        .statusBev (statusBev),
        .epc       (epc),
        .flush     (flushException),
        .excTake   (excTake),
        .eretTake  (eretTake),
        .excCode   (excCode),
        .vector    (excVector)
    );

    cp0Regs uCp0Regs (
        .clk        (clk),
        .arstN      (arstN),
        .interrupt  (interrupt),
        .wrEn       (heldValid && heldCp0Op == cpuPkg::cp0Mtc0),
        .wrAddr     (heldCp0Addr),
        .rdAddr     (heldCp0Addr),
        .wrData     (heldStoreData),    // rt value
        .rdData     (cp0RdData),
        .excTake    (excTake),
        .excCode    (excCode),
        .excPc      (heldPc),
        .eretTake   (eretTake),
        .statusBev  (statusBev),
        .statusExl  (),
        .intPending (intPending),
        .epc        (epc)
    );

    assign stall    = dataReq.valid && !dataReq.done;
    assign memValid = heldValid && !stall;
    assign memRegWr = memValid && heldRegWr && !flushException;   // no write on exception or eret

    always_comb begin
        if (isLoad) begin
            memResult = loadData;
        end else if (heldCp0Op == cpuPkg::cp0Mfc0) begin
            memResult = cp0RdData;
        end else begin
            memResult = heldAluOut;
        end
    end

endmodule

/* hw/apbDataMaster.sv */
// APB3 master for data memory
`timescale 1ns/1ps

module apbDataMaster (
    input  logic           clk,
    input  logic           arstN,
    memReqIf.master        req,
    output cpuPkg::word_t  paddr,
    output cpuPkg::word_t  pwdata,
    output logic           psel,
    output logic           penable,
    output logic           pwrite,
    output cpuPkg::strb_t  pstrb,
    input  cpuPkg::word_t  prdata,
    input  logic           pready
);
    typedef enum logic [1:0] {
        apbIdle,
        apbSetup,
        apbAccess
    } apbState_t;

    apbState_t state;
    apbState_t stateNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= apbIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            apbIdle:   if (req.valid) stateNext = apbSetup;
            apbSetup:  stateNext = apbAccess;
            apbAccess: if (pready) stateNext = apbIdle;   // always one idle cycle after
            default:   stateNext = apbIdle;
        endcase
    end

    // latch the request at launch and hold it through wait states
    always_ff @(posedge clk) begin
        if (state == apbIdle && req.valid) begin
            paddr  <= req.addr;
            pwrite <= req.write;
            pwdata <= req.wdata;
            pstrb  <= req.strb;
        end
    end

    assign psel    = (state != apbIdle);
    assign penable = (state == apbAccess);

    assign req.done  = (state == apbAccess) && pready;
    assign req.rdata = prdata;

endmodule

/* cp0/exceptionUnit.sv */
// Exception priority and vector select
`timescale 1ns/1ps

module exceptionUnit (
    input  logic              valid,
    input  excPkg::excCause_t cause,
    input  logic              isEret,
    input  logic              statusBev,
    input  cpuPkg::word_t     epc,
    output logic              flush,
    output logic              excTake,
    output logic              eretTake,
    output excPkg::excCode_t  excCode,
    output cpuPkg::word_t     vector
);
    logic anyCause;

    assign anyCause = |cause;
    assign excTake  = valid && anyCause;
    assign eretTake = valid && isEret && !anyCause;   // eret loses to any cause
    assign flush    = excTake || eretTake;

    // interrupt first, then address errors, overflow, syscall
    always_comb begin
        if (cause.interrupt) begin
            excCode = excPkg::excInt;
        end else if (cause.adel) begin
            excCode = excPkg::excAdel;
        end else if (cause.ades) begin
            excCode = excPkg::excAdes;
        end else if (cause.overflow) begin
            excCode = excPkg::excOv;
        end else begin
            excCode = excPkg::excSys;
        end
    end

    always_comb begin
        if (excTake) begin
            vector = statusBev ? excPkg::vecBoot : excPkg::vecNormal;
        end else if (eretTake) begin
            vector = epc;
        end else begin
            vector = '0;
        end
    end

endmodule

/* cp0/cp0Regs.sv */
// Reduced coprocessor 0 registers
`timescale 1ns/1ps

module cp0Regs (
    input  logic             clk,
    input  logic             arstN,
    input  cpuPkg::irq_t     interrupt,
    input  logic             wrEn,
    input  excPkg::cp0Addr_t wrAddr,
    input  excPkg::cp0Addr_t rdAddr,
    input  cpuPkg::word_t    wrData,
    output cpuPkg::word_t    rdData,
    input  logic             excTake,
    input  excPkg::excCode_t excCode,
    input  cpuPkg::word_t    excPc,
    input  logic             eretTake,
    output logic             statusBev,
    output logic             statusExl,
    output logic             intPending,
    output cpuPkg::word_t    epc
);
    logic             statusIe;
    logic [7:0]       statusIm;
    logic [7:0]       causeIp;
    excPkg::excCode_t causeExc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            statusBev <= excPkg::statusReset[22];
            statusIm  <= excPkg::statusReset[15:8];
            statusExl <= excPkg::statusReset[1];
            statusIe  <= excPkg::statusReset[0];
            causeIp   <= '0;
            causeExc  <= '0;
            epc       <= '0;
        end else begin
            causeIp[7:2] <= interrupt;      // hardware lines sampled every cycle
            if (excTake) begin
                statusExl <= 1'b1;
                causeExc  <= excCode;
                epc       <= excPc;
            end else if (eretTake) begin
                statusExl <= 1'b0;
            end else if (wrEn) begin
                case (wrAddr)
                    excPkg::cp0Status: begin
                        statusBev <= wrData[22];
                        statusIm  <= wrData[15:8];
                        statusExl <= wrData[1];
                        statusIe  <= wrData[0];
                    end
                    excPkg::cp0Cause: causeIp[1:0] <= wrData[9:8];   // soft irq only
                    excPkg::cp0Epc:   epc <= wrData;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (rdAddr)
            excPkg::cp0Status: rdData = {9'b0, statusBev, 6'b0, statusIm, 6'b0, statusExl, statusIe};
            excPkg::cp0Cause:  rdData = {16'b0, causeIp, 1'b0, causeExc, 2'b0};
            excPkg::cp0Epc:    rdData = epc;
            default:           rdData = '0;
        endcase
    end

    assign intPending = statusIe && !statusExl && |(causeIp & statusIm);

endmodule

/* hw/lsuFormat.sv */
// Load/store lane formatting
`timescale 1ns/1ps

module lsuFormat (
    input  cpuPkg::memOp_t memOp,
    input  cpuPkg::word_t  addr,
    input  cpuPkg::word_t  storeData,
    input  cpuPkg::word_t  rdata,
    output cpuPkg::strb_t  strb,
    output cpuPkg::word_t  wdata,
    output cpuPkg::word_t  loadData,
    output logic           misaligned
);
    logic [1:0]  offset;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;

    assign offset   = addr[1:0];
    assign loadByte = rdata[8*offset +: 8];
    assign loadHalf = offset[1] ? rdata[31:16] : rdata[15:0];

    // replicate the store data into every lane and let the strobe pick one
    always_comb begin
        strb  = '0;
        wdata = storeData;
        case (memOp)
            cpuPkg::memSb: begin
                wdata = {4{storeData[7:0]}};
                strb  = 4'b0001 << offset;
            end
            cpuPkg::memSh: begin
                wdata = {2{storeData[15:0]}};
                strb  = offset[1] ? 4'b1100 : 4'b0011;
            end
            cpuPkg::memSw: strb = 4'b1111;
            default: ;
        endcase
    end

    always_comb begin
        case (memOp)
            cpuPkg::memLb:  loadData = {{24{loadByte[7]}}, loadByte};
            cpuPkg::memLbu: loadData = {24'b0, loadByte};
            cpuPkg::memLh:  loadData = {{16{loadHalf[15]}}, loadHalf};
            cpuPkg::memLhu: loadData = {16'b0, loadHalf};
            default:        loadData = rdata;      // lw
        endcase
    end

    always_comb begin
        case (memOp)
            cpuPkg::memLh, cpuPkg::memLhu, cpuPkg::memSh: misaligned = offset[0];
            cpuPkg::memLw, cpuPkg::memSw:                 misaligned = |offset;
            default:                                      misaligned = 1'b0;
        endcase
    end

endmodule

/* hw/memReg.sv */
// Execute to memory pipeline register
`timescale 1ns/1ps

module memReg (
    input  logic              clk,
    input  logic              arstN,
    input  logic              hold,
    input  logic              flush,
    input  logic              exeValid,
    input  logic              exeSyscall,
    input  logic              exeOverflow,
    input  cpuPkg::word_t     exeAluOut,
    input  cpuPkg::word_t     exeStoreData,
    input  cpuPkg::word_t     exePc,
    input  cpuPkg::regAddr_t  exeDst,
    input  logic              exeRegWr,
    input  cpuPkg::memOp_t    exeMemOp,
    input  cpuPkg::cp0Op_t    exeCp0Op,
    input  excPkg::cp0Addr_t  exeCp0Addr,
    output logic              memValid,
    output logic              memSyscall,
    output logic              memOverflow,
    output cpuPkg::word_t     memAluOut,
    output cpuPkg::word_t     memStoreData,
    output cpuPkg::word_t     memPc,
    output cpuPkg::regAddr_t  memDst,
    output logic              memRegWr,
    output cpuPkg::memOp_t    memMemOp,
    output cpuPkg::cp0Op_t    memCp0Op,
    output excPkg::cp0Addr_t  memCp0Addr
);

    // flush inserts a bubble and hold keeps the current one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memValid <= 1'b0;
        end else if (flush) begin
            memValid <= 1'b0;
        end else if (!hold) begin
            memValid <= exeValid;
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        if (!hold && !flush) begin
            memSyscall   <= exeSyscall;
            memOverflow  <= exeOverflow;
            memAluOut    <= exeAluOut;
            memStoreData <= exeStoreData;
            memPc        <= exePc;
            memDst       <= exeDst;
            memRegWr     <= exeRegWr;
            memMemOp     <= exeMemOp;
            memCp0Op     <= exeCp0Op;
            memCp0Addr   <= exeCp0Addr;
        end
    end

endmodule

/* common/memReqIf.sv */
// Data memory request bundle
`timescale 1ns/1ps

interface memReqIf;
    logic          valid;
    logic          write;
    cpuPkg::word_t addr;   // word aligned
    cpuPkg::strb_t strb;
    cpuPkg::word_t wdata;
    logic          done;   // one cycle pulse
    cpuPkg::word_t rdata;

    modport requester (
        output valid, write, addr, strb, wdata,
        input  done, rdata
    );

    modport master (
        input  valid, write, addr, strb, wdata,
        output done, rdata
    );
endinterface

/* common/excPkg.sv */
// Exception and CP0 definitions
package excPkg;

    typedef logic [4:0] excCode_t;
    typedef logic [4:0] cp0Addr_t;

    // cause codes as written to Cause.ExcCode
    localparam excCode_t excInt  = 5'd0;
    localparam excCode_t excAdel = 5'd4;
    localparam excCode_t excAdes = 5'd5;
    localparam excCode_t excSys  = 5'd8;
    localparam excCode_t excOv   = 5'd12;

    localparam cp0Addr_t cp0Status = 5'd12;
    localparam cp0Addr_t cp0Cause  = 5'd13;
    localparam cp0Addr_t cp0Epc    = 5'd14;

    localparam cpuPkg::word_t vecBoot   = 32'hBFC0_0380;
    localparam cpuPkg::word_t vecNormal = 32'h8000_0180;

    // BEV set, everything else clear
    localparam cpuPkg::word_t statusReset = 32'h0040_0000;

    typedef struct packed {
        logic interrupt;
        logic adel;
        logic ades;
        logic syscall;
        logic overflow;
    } excCause_t;

endpackage

/* common/cpuPkg.sv */
// Pipeline types for the memory stage
package cpuPkg;

    localparam int wordBits  = 32;
    localparam int laneCount = wordBits / 8;
    localparam int regBits   = 5;
    localparam int irqLines  = 6;

    // data or address word
    typedef logic [wordBits-1:0] word_t;

    // register file index
    typedef logic [regBits-1:0] regAddr_t;

    // one bit per byte lane
    typedef logic [laneCount-1:0] strb_t;

    // hardware interrupt lines, IP7..2
    typedef logic [irqLines-1:0] irq_t;

    // load/store kind carried down from decode
    typedef enum logic [3:0] {
        memNone,
        memLb,
        memLbu,
        memLh,
        memLhu,
        memLw,
        memSb,
        memSh,
        memSw
    } memOp_t;

    // coprocessor 0 operation
    typedef enum logic [1:0] {
        cp0None,
        cp0Mfc0,
        cp0Mtc0,
        cp0Eret
    } cp0Op_t;

endpackage
